/* hdl/fetch_pkg.sv */
// Shared types and line constants for the instruction fetch stage.
// Referenced by scoped name from the fetch modules.

package fetch_pkg;

   // One memory line fills the whole decode window
   parameter int LINE_BYTES = 16;
   parameter int LINE_OFFW  = 4;

   // Address generator sequencing
   typedef enum logic [1:0] {
      // No load since reset or flush
      AG_IDLE = 2'd0,
      // Free to request the next line
      AG_RUN  = 2'd1,
      // One request outstanding
      AG_WAIT = 2'd2
   } ag_state_e;

   // Outstanding response tracking
   typedef enum logic [1:0] {
      RF_IDLE = 2'd0,
      // Response due, goes to the queue
      RF_PEND = 2'd1,
      // Response due, made stale by a flush or load
      RF_DROP = 2'd2
   } rf_state_e;

endpackage

/* hdl/pc_tracker.sv */
// Redirect and program counter registers of the fetch stage.
// Tracks the code segment offset of the decode window and steers
// the address generator and the instruction queue on load and flush.

`timescale 1ns/1ps

module pc_tracker #(
   parameter int IADDRW = 32
) (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic                           load_i,
   input  logic                           flush_i,
   input  logic [IADDRW-1:0]              load_address_i,
   input  logic [15:0]                    cs_register_i,
   input  logic                           transfer_i,
   input  logic [4:0]                     bytes_read_i,
   output logic [IADDRW-1:0]              f_pc_o,
   output logic                           redirect_o,
   output logic [IADDRW-1:0]              start_line_o,
   output logic [fetch_pkg::LINE_OFFW-1:0] skip_bytes_o,
   output logic                           fetch_enable_o
);

   // Both a load and a flush restart the stage
   assign redirect_o   = load_i | flush_i;
   assign start_line_o = {load_address_i[IADDRW-1:fetch_pkg::LINE_OFFW],
                          {fetch_pkg::LINE_OFFW{1'b0}}};

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         f_pc_o         <= '0;
         skip_bytes_o   <= '0;
         fetch_enable_o <= 1'b0;
      end else if (load_i) begin
         // Offset within the code segment
         f_pc_o         <= load_address_i - IADDRW'(cs_register_i);
         skip_bytes_o   <= load_address_i[fetch_pkg::LINE_OFFW-1:0];
         fetch_enable_o <= 1'b1;
      end else if (flush_i) begin
         skip_bytes_o   <= '0;
         fetch_enable_o <= 1'b0;
      end else if (transfer_i) begin
         f_pc_o <= f_pc_o + IADDRW'(bytes_read_i);
      end
   end

   // Control must never ask for both at once
   a_no_load_flush : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(load_i && flush_i));

endmodule

/* hdl/address_generation.sv */
// Line request sequencer for instruction memory.
// Issues aligned 16 byte line requests, one at a time, only while the
// instruction queue has room for a whole line.

`timescale 1ns/1ps

module address_generation #(
   parameter int IADDRW = 32
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              redirect_i,
   input  logic              fetch_enable_i,
   input  logic [IADDRW-1:0] start_line_i,
   input  logic              room_i,
   input  logic              response_done_i,
   output logic              imem_valid_o,
   input  logic              imem_ready_i,
   output logic [IADDRW-1:0] imem_address_o,
   output logic              req_accept_o
);

   fetch_pkg::ag_state_e state_q;

   assign imem_valid_o = (state_q == fetch_pkg::AG_RUN) && fetch_enable_i && room_i;
   assign req_accept_o = imem_valid_o && imem_ready_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= fetch_pkg::AG_IDLE;
      end else if (redirect_i) begin
         // A request in flight must finish before the new stream starts
         if (req_accept_o || (state_q == fetch_pkg::AG_WAIT && !response_done_i))
            state_q <= fetch_pkg::AG_WAIT;
         else
            state_q <= fetch_pkg::AG_RUN;
      end else begin
         case (state_q)
            fetch_pkg::AG_RUN: begin
               if (!fetch_enable_i)
                  state_q <= fetch_pkg::AG_IDLE;
               else if (req_accept_o)
                  state_q <= fetch_pkg::AG_WAIT;
            end
            fetch_pkg::AG_WAIT: begin
               if (response_done_i)
                  state_q <= fetch_enable_i ? fetch_pkg::AG_RUN : fetch_pkg::AG_IDLE;
            end
            default: state_q <= state_q;
         endcase
      end
   end

   // Line address moves one line per accepted request
   always_ff @(posedge clk) begin
      if (redirect_i)
         imem_address_o <= start_line_i;
      else if (req_accept_o)
         imem_address_o <= imem_address_o + IADDRW'(fetch_pkg::LINE_BYTES);
   end

   // A waiting request keeps valid and its address until memory takes it
   a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
      (imem_valid_o && !imem_ready_i && !redirect_i) |=>
         (imem_valid_o && $stable(imem_address_o)));

endmodule

/* hdl/response_filter.sv */
// Outstanding request tracker for the memory response path.
// Passes the response of a live request on to the queue and swallows
// one that a flush or load has made stale.

`timescale 1ns/1ps

module response_filter (
   input  logic clk,
   input  logic rst_n_i,
   input  logic redirect_i,
   input  logic req_accept_i,
   input  logic imem_dp_valid_i,
   input  logic imem_dp_ready_i,
   output logic keep_valid_o,
   output logic response_done_o
);

   fetch_pkg::rf_state_e state_q;

   assign keep_valid_o    = imem_dp_valid_i && (state_q == fetch_pkg::RF_PEND);
   assign response_done_o = imem_dp_valid_i && imem_dp_ready_i &&
                            (state_q != fetch_pkg::RF_IDLE);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= fetch_pkg::RF_IDLE;
      end else begin
         case (state_q)
            fetch_pkg::RF_IDLE: begin
               // Request taken in the redirect cycle belongs to the old stream
               if (req_accept_i)
                  state_q <= redirect_i ? fetch_pkg::RF_DROP : fetch_pkg::RF_PEND;
            end
            fetch_pkg::RF_PEND: begin
               if (response_done_o)
                  state_q <= fetch_pkg::RF_IDLE;
               else if (redirect_i)
                  state_q <= fetch_pkg::RF_DROP;
            end
            fetch_pkg::RF_DROP: begin
               if (response_done_o)
                  state_q <= fetch_pkg::RF_IDLE;
            end
            default: state_q <= fetch_pkg::RF_IDLE;
         endcase
      end
   end

   // Memory only answers requests it accepted
   a_no_orphan_resp : assert property (@(posedge clk) disable iff (!rst_n_i)
      imem_dp_valid_i |-> (state_q != fetch_pkg::RF_IDLE));

endmodule

/* hdl/instruction_queue.sv */
// Byte queue between instruction memory and decode.
// Takes whole lines, drops the leading bytes of the first line after a
// redirect and shows up to 16 bytes from the read pointer to decode.

`timescale 1ns/1ps

module instruction_queue #(
   parameter int IDATAW   = 128,
   parameter int IQ_LINES = 2
) (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            redirect_i,
   input  logic [fetch_pkg::LINE_OFFW-1:0] skip_bytes_i,
   input  logic                            line_valid_i,
   input  logic [IDATAW-1:0]               line_data_i,
   output logic                            line_ready_o,
   output logic                            room_o,
   output logic                            f_valid_o,
   input  logic                            f_ready_i,
   input  logic [4:0]                      bytes_read_i,
   output logic [4:0]                      valid_bytes_o,
   output logic [IDATAW-1:0]               window_o
);

   localparam int DEPTH = IQ_LINES * fetch_pkg::LINE_BYTES;
   localparam int PTRW  = $clog2(DEPTH);
   localparam int CNTW  = $clog2(DEPTH + 1);

   logic [7:0]                      mem_q [DEPTH];
   logic [PTRW-1:0]                 rd_q;
   logic [PTRW-1:0]                 wr_q;
   logic [CNTW-1:0]                 count_q;
   logic                            first_q;
   logic                            line_take;
   logic                            transfer;
   logic [fetch_pkg::LINE_OFFW-1:0] skip;
   logic [4:0]                      wr_bytes;
   logic [IDATAW-1:0]               line_shift;

   // Circular index, the sum is always below twice the depth
   function automatic logic [PTRW-1:0] wrap(input logic [PTRW:0] sum);
      if (int'(sum) >= DEPTH)
         return PTRW'(int'(sum) - DEPTH);
      return sum[PTRW-1:0];
   endfunction

   // The outstanding line is only requested with a line free, so the
   // space is held until it lands
   assign room_o       = (int'(count_q) + fetch_pkg::LINE_BYTES) <= DEPTH;
   assign line_ready_o = room_o;
   assign line_take    = line_valid_i && line_ready_o;

   assign f_valid_o     = (count_q != '0);
   assign transfer      = f_valid_o && f_ready_i;
   assign valid_bytes_o = (int'(count_q) >= fetch_pkg::LINE_BYTES) ? 5'd16 : 5'(count_q);

   // Only the first line after a redirect starts mid line
   assign skip       = first_q ? skip_bytes_i : '0;
   assign wr_bytes   = 5'd16 - {1'b0, skip};
   assign line_shift = line_data_i >> {skip, 3'b000};

   always_comb begin
      for (int i = 0; i < fetch_pkg::LINE_BYTES; i++) begin
         window_o[i*8 +: 8] = mem_q[wrap({1'b0, rd_q} + (PTRW+1)'(i))];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_q    <= '0;
         wr_q    <= '0;
         count_q <= '0;
         first_q <= 1'b1;
      end else if (redirect_i) begin
         rd_q    <= '0;
         wr_q    <= '0;
         count_q <= '0;
         first_q <= 1'b1;
      end else begin
         if (line_take) begin
            wr_q    <= wrap({1'b0, wr_q} + (PTRW+1)'(wr_bytes));
            first_q <= 1'b0;
         end
         if (transfer)
            rd_q <= wrap({1'b0, rd_q} + (PTRW+1)'(bytes_read_i));
         count_q <= count_q + (line_take ? CNTW'(wr_bytes) : '0)
                            - (transfer ? CNTW'(bytes_read_i) : '0);
      end
   end

   // Byte storage
   always_ff @(posedge clk) begin
      if (line_take && !redirect_i) begin
         for (int j = 0; j < fetch_pkg::LINE_BYTES; j++) begin
            if (5'(j) < wr_bytes)
               mem_q[wrap({1'b0, wr_q} + (PTRW+1)'(j))] <= line_shift[j*8 +: 8];
         end
      end
   end

   // Decode may not take bytes it was not shown
   a_read_in_window : assert property (@(posedge clk) disable iff (!rst_n_i)
      (f_valid_o && f_ready_i) |-> (bytes_read_i <= valid_bytes_o));

endmodule

/* hdl/fetch_top.sv */
// Top level of the instruction fetch stage.
// Connects the pc tracker, address generator, response filter and
// instruction queue between instruction memory and decode.

`timescale 1ns/1ps

module fetch_top #(
   parameter int IADDRW   = 32,
   parameter int IDATAW   = 128,
   parameter int IQ_LINES = 2
) (
   input  logic              clk,
   input  logic              rst_n_i,

   // Control
   input  logic              flush_i,
   input  logic              load_i,
   input  logic [IADDRW-1:0] load_address_i,
   input  logic [15:0]       cs_register_i,

   // Instruction memory request and response
   output logic              imem_valid_o,
   input  logic              imem_ready_i,
   output logic [IADDRW-1:0] imem_address_o,
   input  logic              imem_dp_valid_i,
   output logic              imem_dp_ready_o,
   input  logic [IDATAW-1:0] imem_dp_read_data_i,

   // Decode
   output logic              f_valid_o,
   input  logic              f_ready_i,
   input  logic [4:0]        f_bytes_read_i,
   output logic [4:0]        f_valid_bytes_o,
   output logic [IDATAW-1:0] f_instruction_o,
   output logic [IADDRW-1:0] f_pc_o
);

   logic                            redirect;
   logic [IADDRW-1:0]               start_line;
   logic [fetch_pkg::LINE_OFFW-1:0] skip_bytes;
   logic                            fetch_enable;
   logic                            room;
   logic                            req_accept;
   logic                            keep_valid;
   logic                            response_done;
   logic                            transfer;

   assign transfer = f_valid_o & f_ready_i;

   pc_tracker #(.IADDRW(IADDRW)) pc_tracker_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .load_i         (load_i),
      .flush_i        (flush_i),
      .load_address_i (load_address_i),
      .cs_register_i  (cs_register_i),
      .transfer_i     (transfer),
      .bytes_read_i   (f_bytes_read_i),
      .f_pc_o         (f_pc_o),
      .redirect_o     (redirect),
      .start_line_o   (start_line),
      .skip_bytes_o   (skip_bytes),
      .fetch_enable_o (fetch_enable)
   );

   address_generation #(.IADDRW(IADDRW)) address_generation_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .redirect_i      (redirect),
      .fetch_enable_i  (fetch_enable),
      .start_line_i    (start_line),
      .room_i          (room),
      .response_done_i (response_done),
      .imem_valid_o    (imem_valid_o),
      .imem_ready_i    (imem_ready_i),
      .imem_address_o  (imem_address_o),
      .req_accept_o    (req_accept)
   );

   response_filter response_filter_inst (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .redirect_i      (redirect),
      .req_accept_i    (req_accept),
      .imem_dp_valid_i (imem_dp_valid_i),
      .imem_dp_ready_i (imem_dp_ready_o),
      .keep_valid_o    (keep_valid),
      .response_done_o (response_done)
   );

   instruction_queue #(
      .IDATAW   (IDATAW),
      .IQ_LINES (IQ_LINES)
   ) instruction_queue_inst (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .redirect_i    (redirect),
      .skip_bytes_i  (skip_bytes),
      .line_valid_i  (keep_valid),
      .line_data_i   (imem_dp_read_data_i),
      .line_ready_o  (imem_dp_ready_o),
      .room_o        (room),
      .f_valid_o     (f_valid_o),
      .f_ready_i     (f_ready_i),
      .bytes_read_i  (f_bytes_read_i),
      .valid_bytes_o (f_valid_bytes_o),
      .window_o      (f_instruction_o)
   );

endmodule

/* test/fetch_tb.sv */
// Testbench for the instruction fetch stage.
// Models instruction memory and a random decode consumer, and checks
// the decode window and program counter against a reference model.

`timescale 1ns/1ps

module fetch_tb;

   localparam int IQ_LINES    = 2;
   localparam int CLK_PERIOD  = 40;
   localparam int NUM_TESTS   = 6;
   localparam int TEST_BUDGET = 400;
   localparam int WAIT_LIMIT  = 300;

   logic         clk;
   logic         rst_n_i;
   logic         flush_i;
   logic         load_i;
   logic [31:0]  load_address_i;
   logic [15:0]  cs_register_i;
   logic         imem_valid_o;
   logic         imem_ready_i;
   logic [31:0]  imem_address_o;
   logic         imem_dp_valid_i;
   logic         imem_dp_ready_o;
   logic [127:0] imem_dp_read_data_i;
   logic         f_valid_o;
   logic         f_ready_i;
   logic [4:0]   f_bytes_read_i;
   logic [4:0]   f_valid_bytes_o;
   logic [127:0] f_instruction_o;
   logic [31:0]  f_pc_o;

   int          seed = 32'h7898;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          consumed;
   int          mem_delay;
   logic        idle;
   logic        hold_decode;
   logic        req_taken;
   logic        resp_taken;
   logic        mem_pend;
   logic [31:0] req_addr;
   logic [31:0] mem_addr;
   logic [31:0] model_pc;
   logic [31:0] model_lin;

   fetch_top #(
      .IADDRW   (32),
      .IDATAW   (128),
      .IQ_LINES (IQ_LINES)
   ) fetch_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Reference memory where each byte is a function of its address
   function automatic logic [7:0] mem_byte(input logic [31:0] addr);
      return addr[7:0] ^ addr[15:8];
   endfunction

   function automatic logic [127:0] mem_line(input logic [31:0] addr);
      logic [127:0] line;
      for (int k = 0; k < 16; k++)
         line[k*8 +: 8] = mem_byte(addr + 32'(k));
      return line;
   endfunction

   // Lowest shown window byte that differs from memory or -1 if none
   function automatic int first_bad_byte();
      int bad;
      bad = -1;
      for (int i = 15; i >= 0; i--) begin
         if (i < int'(f_valid_bytes_o) &&
             f_instruction_o[i*8 +: 8] !== mem_byte(model_lin + 32'(i)))
            bad = i;
      end
      return bad;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   // Compares in mid cycle and then steps the model over the coming edge
   always @(negedge clk) begin
      int bad;
      if (rst_n_i) begin
         if (idle && (imem_valid_o || f_valid_o))
            report_error("fetch active while no load is in effect");
         if (f_pc_o !== model_pc)
            report_error($sformatf("f_pc_o is %h, expected %h", f_pc_o, model_pc));
         if (!idle && f_valid_o) begin
            bad = first_bad_byte();
            if (f_valid_bytes_o == 5'd0 || f_valid_bytes_o > 5'd16)
               report_error($sformatf("f_valid_bytes_o is %0d", f_valid_bytes_o));
            if (bad >= 0)
               report_error($sformatf("window byte %0d is %h, expected %h", bad,
                  f_instruction_o[bad*8 +: 8], mem_byte(model_lin + 32'(bad))));
         end
         if (!idle && imem_valid_o && imem_address_o > model_lin + 32'((IQ_LINES + 1) * 16))
            report_error($sformatf("request %h runs too far past window start %h",
               imem_address_o, model_lin));
         if (load_i) begin
            model_pc  = load_address_i - {16'h0000, cs_register_i};
            model_lin = load_address_i;
            idle      = 1'b0;
         end else if (flush_i) begin
            idle = 1'b1;
         end else if (f_valid_o && f_ready_i) begin
            model_pc  = model_pc + 32'(f_bytes_read_i);
            model_lin = model_lin + 32'(f_bytes_read_i);
            consumed += int'(f_bytes_read_i);
         end
      end
   end

   // Instruction memory model with one request at a time and 0 to 3 cycles of latency
   task automatic memory_step();
      if (resp_taken)
         imem_dp_valid_i = 1'b0;
      if (req_taken) begin
         mem_pend  = 1'b1;
         mem_addr  = req_addr;
         mem_delay = $unsigned($random(seed)) % 4;
      end
      if (mem_pend && !imem_dp_valid_i) begin
         if (mem_delay == 0) begin
            imem_dp_valid_i     = 1'b1;
            imem_dp_read_data_i = mem_line(mem_addr);
            mem_pend            = 1'b0;
         end else begin
            mem_delay--;
         end
      end
      imem_ready_i = ($unsigned($random(seed)) % 4) != 0;
   endtask

   task automatic decode_step();
      f_ready_i      = !hold_decode && ($unsigned($random(seed)) % 4 != 0);
      f_bytes_read_i = 5'($unsigned($random(seed)) % (32'(f_valid_bytes_o) + 1));
   endtask

   // Handshakes are sampled mid cycle and new inputs go out 2 ns after the edge
   task automatic cycle();
      @(negedge clk);
      req_taken  = imem_valid_o && imem_ready_i;
      resp_taken = imem_dp_valid_i && imem_dp_ready_o;
      req_addr   = imem_address_o;
      @(posedge clk);
      #2;
      memory_step();
      decode_step();
   endtask

   task automatic load_stream(input logic [31:0] addr, input logic [15:0] cs);
      cycle();
      load_i         = 1'b1;
      load_address_i = addr;
      cs_register_i  = cs;
      cycle();
      load_i   = 1'b0;
      consumed = 0;
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      while (!f_valid_o && n < WAIT_LIMIT) begin
         cycle();
         n++;
      end
      if (!f_valid_o) begin
         errors++;
         $display("Timed out at %0t waiting for the first decode window", $time);
      end
   endtask

   task automatic wait_consumed(input int bytes);
      int n;
      n = 0;
      while (consumed < bytes && n < WAIT_LIMIT) begin
         cycle();
         n++;
      end
      if (consumed < bytes) begin
         errors++;
         $display("Timed out at %0t with %0d of %0d bytes consumed", $time, consumed, bytes);
      end
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      tests_run++;
      if (errors != errs_at_start) begin
         tests_failed++;
         $display("Test %s: FAIL with %0d errors", name, errors - errs_at_start);
      end else begin
         $display("Test %s: PASS", name);
      end
   endtask

   initial begin
      int start_errs;
      int n;
      rst_n_i             = 1'b0;
      flush_i             = 1'b0;
      load_i              = 1'b0;
      load_address_i      = '0;
      cs_register_i       = '0;
      imem_ready_i        = 1'b0;
      imem_dp_valid_i     = 1'b0;
      imem_dp_read_data_i = '0;
      f_ready_i           = 1'b0;
      f_bytes_read_i      = '0;
      idle                = 1'b1;
      hold_decode         = 1'b0;
      mem_pend            = 1'b0;
      mem_delay           = 0;
      model_pc            = '0;
      model_lin           = '0;
      consumed            = 0;
      repeat (2) cycle();
      rst_n_i = 1'b1;

      start_errs = errors;
      repeat (20) cycle();
      end_test("idle before load", start_errs);

      start_errs = errors;
      load_stream(32'h0000_1200, 16'h0100);
      wait_valid();
      if (f_pc_o !== 32'h0000_1100)
         report_error($sformatf("f_pc_o after load is %h, expected 00001100", f_pc_o));
      wait_consumed(96);
      end_test("aligned load", start_errs);

      // Load while the previous stream is still fetching
      start_errs = errors;
      load_stream(32'h0000_2A37, 16'h0230);
      wait_valid();
      if (f_instruction_o[7:0] !== mem_byte(32'h0000_2A37))
         report_error($sformatf("first window byte is %h", f_instruction_o[7:0]));
      wait_consumed(64);
      end_test("unaligned load", start_errs);

      start_errs = errors;
      load_stream(32'h0000_3F0B, 16'h0F00);
      wait_consumed(200);
      if (f_pc_o !== 32'h0000_300B + 32'(consumed))
         report_error($sformatf("f_pc_o is %h after %0d bytes", f_pc_o, consumed));
      end_test("random consumption", start_errs);

      start_errs = errors;
      hold_decode = 1'b1;
      load_stream(32'h0000_4C05, 16'h0000);
      repeat (60) cycle();
      if (f_valid_bytes_o !== 5'd16)
         report_error($sformatf("f_valid_bytes_o is %0d under back-pressure", f_valid_bytes_o));
      if (imem_valid_o)
         report_error("request issued with a full queue");
      hold_decode = 1'b0;
      consumed    = 0;
      wait_consumed(96);
      end_test("back-pressure", start_errs);

      start_errs = errors;
      load_stream(32'h0000_6010, 16'h0010);
      n = 0;
      while (!mem_pend && n < WAIT_LIMIT) begin
         cycle();
         n++;
      end
      if (!mem_pend) begin
         errors++;
         $display("Timed out at %0t waiting for an outstanding request", $time);
      end
      flush_i = 1'b1;
      cycle();
      flush_i = 1'b0;
      repeat (8) cycle();
      if (mem_pend || imem_dp_valid_i) begin
         errors++;
         $display("Stale response was never taken by the fetch stage");
      end
      load_stream(32'h0000_9A4E, 16'h0200);
      wait_consumed(80);
      end_test("flush with response outstanding", start_errs);

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial begin
      #(4 * NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
      $display("Watchdog expired at %0t before the tests completed", $time);
      $display("Errors found");
      $finish;
   end

endmodule

/* vlog.f */
hdl/fetch_pkg.sv
hdl/pc_tracker.sv
hdl/address_generation.sv
hdl/response_filter.sv
hdl/instruction_queue.sv
hdl/fetch_top.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it.

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module fetch_tb \
   -Mdir "$BUILD_DIR" -o fetch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/fetch_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Errors found" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation passed"
exit 0
